// ==== Bender.yml ====
package:
  name: controlUnit

sources:
  - files:
      - common/ctrlPkg.sv
      - controlUnit/instrDecoder.sv
      - controlUnit/phaseSequencer.sv
      - controlUnit/controlEncoder.sv
      - controlUnit/controlUnit.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/controlUnitTb.sv

// ==== common/ctrlPkg.sv ====
package ctrlPkg;

    // Instruction field widths
    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;

    // Primary opcodes handled by this control unit
    typedef enum logic [opcodeWidth-1:0] {
        opRType = 6'b000000,
        opJump  = 6'b000010,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001
    } opcodeT;

    // Funct codes of the register class
    typedef enum logic [functWidth-1:0] {
        functAdd = 6'b100000,
        functSub = 6'b100010,
        functAnd = 6'b100100,
        functSlt = 6'b101010
    } functT;

    typedef enum logic [2:0] {
        instrAdd     = 3'd0,
        instrSub     = 3'd1,
        instrAnd     = 3'd2,
        instrSlt     = 3'd3,
        instrAddi    = 3'd4,
        instrAddiu   = 3'd5,
        instrJump    = 3'd6,
        instrUnknown = 3'd7
    } instrKindT;

    typedef enum logic [2:0] {
        stateReset     = 3'd0,
        stateFetch     = 3'd1,
        stateDecode    = 3'd2,
        stateAluExec   = 3'd3,
        stateAluWrite  = 3'd4,
        stateJump      = 3'd5,
        stateException = 3'd6
    } ctrlStateT;

    // ALU first operand
    localparam int aluSrcAWidth = 2;
    localparam logic [aluSrcAWidth-1:0] aluSrcAPc = 2'b00;
    localparam logic [aluSrcAWidth-1:0] aluSrcAReg = 2'b10;

    // ALU second operand
    localparam int aluSrcBWidth = 3;
    localparam logic [aluSrcBWidth-1:0] aluSrcBReg = 3'b000;
    localparam logic [aluSrcBWidth-1:0] aluSrcBFour = 3'b001;
    localparam logic [aluSrcBWidth-1:0] aluSrcBImm = 3'b010;
    localparam logic [aluSrcBWidth-1:0] aluSrcBBranch = 3'b011;

    // ALU function, compare used for SLT
    localparam int aluOpWidth = 3;
    localparam logic [aluOpWidth-1:0] aluOpAdd = 3'b001;
    localparam logic [aluOpWidth-1:0] aluOpSub = 3'b010;
    localparam logic [aluOpWidth-1:0] aluOpAnd = 3'b011;
    localparam logic [aluOpWidth-1:0] aluOpSlt = 3'b111;

    // Next PC source
    localparam int pcSourceWidth = 3;
    localparam logic [pcSourceWidth-1:0] pcSrcAluResult = 3'b010;
    localparam logic [pcSourceWidth-1:0] pcSrcJumpTarget = 3'b011;
    localparam logic [pcSourceWidth-1:0] pcSrcExcVector = 3'b100;

    // Register file write address
    localparam int regDstWidth = 2;
    localparam logic [regDstWidth-1:0] regDstRt = 2'b00;
    localparam logic [regDstWidth-1:0] regDstRd = 2'b01;

    // Exception cause recorded with EPC
    localparam int causeWidth = 2;
    localparam logic [causeWidth-1:0] causeOpcode = 2'b00;
    localparam logic [causeWidth-1:0] causeOverflow = 2'b01;

endpackage

// ==== controlUnit.f ====
common/ctrlPkg.sv
controlUnit/instrDecoder.sv
controlUnit/phaseSequencer.sv
controlUnit/controlEncoder.sv
controlUnit/controlUnit.sv
dv/clockGen.sv
dv/controlUnitTb.sv

// ==== controlUnit/controlEncoder.sv ====
`timescale 1ns/1ps

module controlEncoder #(
    parameter int fetchCycles = 4,
    parameter int decodeCycles = 2
) (
    input  ctrlPkg::ctrlStateT state,
    input  logic [$clog2(((fetchCycles > decodeCycles) ? fetchCycles : decodeCycles) + 1)-1:0]
        phaseCount,
    input  ctrlPkg::instrKindT latchedKind,
    input  logic [ctrlPkg::causeWidth-1:0] exceptionCause,
    output logic irWrite,
    output logic pcWrite,
    output logic writeA,
    output logic writeB,
    output logic aluOutWrite,
    output logic regWrite,
    output logic epcWrite,
    output logic resetOut,
    output logic [ctrlPkg::aluSrcAWidth-1:0] aluSrcA,
    output logic [ctrlPkg::aluSrcBWidth-1:0] aluSrcB,
    output logic [ctrlPkg::aluOpWidth-1:0] aluOperation,
    output logic [ctrlPkg::pcSourceWidth-1:0] pcSource,
    output logic [ctrlPkg::regDstWidth-1:0] regDst,
    output logic [ctrlPkg::causeWidth-1:0] causeControl
);

    localparam int maxCycles = (fetchCycles > decodeCycles) ? fetchCycles : decodeCycles;
    localparam int countWidth = $clog2(maxCycles + 1);
    localparam logic [countWidth-1:0] lastFetch = countWidth'(fetchCycles - 1);

    logic immediateKind;

    assign immediateKind = (latchedKind == ctrlPkg::instrAddi) ||
                           (latchedKind == ctrlPkg::instrAddiu);

    always_comb begin
        irWrite = 1'b0;
        pcWrite = 1'b0;
        writeA = 1'b0;
        writeB = 1'b0;
        aluOutWrite = 1'b0;
        regWrite = 1'b0;
        epcWrite = 1'b0;
        resetOut = 1'b0;
        aluSrcA = '0;
        aluSrcB = '0;
        aluOperation = '0;
        pcSource = '0;
        regDst = '0;
        causeControl = '0;

        case (state)
            ctrlPkg::stateReset: begin
                resetOut = 1'b1;
            end
            ctrlPkg::stateFetch: begin
                // PC + 4, committed together with the IR load
                aluSrcA = ctrlPkg::aluSrcAPc;
                aluSrcB = ctrlPkg::aluSrcBFour;
                aluOperation = ctrlPkg::aluOpAdd;
                pcSource = ctrlPkg::pcSrcAluResult;
                if (phaseCount == lastFetch) begin
                    irWrite = 1'b1;
                    pcWrite = 1'b1;
                end
            end
            ctrlPkg::stateDecode: begin
                writeA = 1'b1;
                writeB = 1'b1;
                aluOutWrite = 1'b1;
                aluSrcA = ctrlPkg::aluSrcAPc;
                aluSrcB = ctrlPkg::aluSrcBBranch;
                aluOperation = ctrlPkg::aluOpAdd;
            end
            ctrlPkg::stateAluExec: begin
                aluOutWrite = 1'b1;
                aluSrcA = ctrlPkg::aluSrcAReg;
                aluSrcB = immediateKind ? ctrlPkg::aluSrcBImm : ctrlPkg::aluSrcBReg;
                case (latchedKind)
                    ctrlPkg::instrSub: aluOperation = ctrlPkg::aluOpSub;
                    ctrlPkg::instrAnd: aluOperation = ctrlPkg::aluOpAnd;
                    ctrlPkg::instrSlt: aluOperation = ctrlPkg::aluOpSlt;
                    default: aluOperation = ctrlPkg::aluOpAdd;
                endcase
            end
            ctrlPkg::stateAluWrite: begin
                regWrite = 1'b1;
                regDst = immediateKind ? ctrlPkg::regDstRt : ctrlPkg::regDstRd;
            end
            ctrlPkg::stateJump: begin
                pcWrite = 1'b1;
                pcSource = ctrlPkg::pcSrcJumpTarget;
            end
            ctrlPkg::stateException: begin
                epcWrite = 1'b1;
                pcWrite = 1'b1;
                pcSource = ctrlPkg::pcSrcExcVector;
                causeControl = exceptionCause;
            end
            default: begin
                resetOut = 1'b0;
            end
        endcase
    end

endmodule

// ==== controlUnit/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit #(
    parameter int fetchCycles = 4,
    parameter int decodeCycles = 2
) (
    input  logic clk,
    input  logic reset,
    input  ctrlPkg::opcodeT opcode,
    input  ctrlPkg::functT funct,
    input  logic overflow,
    output logic irWrite,
    output logic pcWrite,
    output logic writeA,
    output logic writeB,
    output logic aluOutWrite,
    output logic regWrite,
    output logic epcWrite,
    output logic resetOut,
    output logic [ctrlPkg::aluSrcAWidth-1:0] aluSrcA,
    output logic [ctrlPkg::aluSrcBWidth-1:0] aluSrcB,
    output logic [ctrlPkg::aluOpWidth-1:0] aluOperation,
    output logic [ctrlPkg::pcSourceWidth-1:0] pcSource,
    output logic [ctrlPkg::regDstWidth-1:0] regDst,
    output logic [ctrlPkg::causeWidth-1:0] causeControl
);

    localparam int maxCycles = (fetchCycles > decodeCycles) ? fetchCycles : decodeCycles;
    localparam int countWidth = $clog2(maxCycles + 1);

    ctrlPkg::instrKindT instrKind;
    ctrlPkg::instrKindT latchedKind;
    ctrlPkg::ctrlStateT state;
    logic trapsOnOverflow;
    logic [countWidth-1:0] phaseCount;
    logic [ctrlPkg::causeWidth-1:0] exceptionCause;

    instrDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .instrKind(instrKind),
        .trapsOnOverflow(trapsOnOverflow)
    );

    phaseSequencer #(
        .fetchCycles(fetchCycles),
        .decodeCycles(decodeCycles)
    ) sequencer (
        .clk(clk),
        .reset(reset),
        .instrKind(instrKind),
        .trapsOnOverflow(trapsOnOverflow),
        .overflow(overflow),
        .state(state),
        .phaseCount(phaseCount),
        .latchedKind(latchedKind),
        .exceptionCause(exceptionCause)
    );

    controlEncoder #(
        .fetchCycles(fetchCycles),
        .decodeCycles(decodeCycles)
    ) encoder (
        .state(state),
        .phaseCount(phaseCount),
        .latchedKind(latchedKind),
        .exceptionCause(exceptionCause),
        .irWrite(irWrite),
        .pcWrite(pcWrite),
        .writeA(writeA),
        .writeB(writeB),
        .aluOutWrite(aluOutWrite),
        .regWrite(regWrite),
        .epcWrite(epcWrite),
        .resetOut(resetOut),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .aluOperation(aluOperation),
        .pcSource(pcSource),
        .regDst(regDst),
        .causeControl(causeControl)
    );

endmodule

// ==== controlUnit/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  ctrlPkg::opcodeT opcode,
    input  ctrlPkg::functT funct,
    output ctrlPkg::instrKindT instrKind,
    output logic trapsOnOverflow
);

    // Opcode first, funct only matters for the register class
    always_comb begin
        instrKind = ctrlPkg::instrUnknown;
        case (opcode)
            ctrlPkg::opRType: begin
                case (funct)
                    ctrlPkg::functAdd: begin
                        instrKind = ctrlPkg::instrAdd;
                    end
                    ctrlPkg::functSub: begin
                        instrKind = ctrlPkg::instrSub;
                    end
                    ctrlPkg::functAnd: begin
                        instrKind = ctrlPkg::instrAnd;
                    end
                    ctrlPkg::functSlt: begin
                        instrKind = ctrlPkg::instrSlt;
                    end
                    default: begin
                        instrKind = ctrlPkg::instrUnknown;
                    end
                endcase
            end
            ctrlPkg::opAddi: begin
                instrKind = ctrlPkg::instrAddi;
            end
            ctrlPkg::opAddiu: begin
                instrKind = ctrlPkg::instrAddiu;
            end
            ctrlPkg::opJump: begin
                instrKind = ctrlPkg::instrJump;
            end
            default: begin
                instrKind = ctrlPkg::instrUnknown;
            end
        endcase
    end

    // Signed arithmetic only, ADDIU never traps
    always_comb begin
        case (instrKind)
            ctrlPkg::instrAdd,
            ctrlPkg::instrSub,
            ctrlPkg::instrAddi: begin
                trapsOnOverflow = 1'b1;
            end
            default: begin
                trapsOnOverflow = 1'b0;
            end
        endcase
    end

endmodule

// ==== controlUnit/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer #(
    parameter int fetchCycles = 4,
    parameter int decodeCycles = 2
) (
    input  logic clk,
    input  logic reset,
    input  ctrlPkg::instrKindT instrKind,
    input  logic trapsOnOverflow,
    input  logic overflow,
    output ctrlPkg::ctrlStateT state,
    output logic [$clog2(((fetchCycles > decodeCycles) ? fetchCycles : decodeCycles) + 1)-1:0]
        phaseCount,
    output ctrlPkg::instrKindT latchedKind,
    output logic [ctrlPkg::causeWidth-1:0] exceptionCause
);

    localparam int maxCycles = (fetchCycles > decodeCycles) ? fetchCycles : decodeCycles;
    localparam int countWidth = $clog2(maxCycles + 1);
    localparam logic [countWidth-1:0] lastFetch = countWidth'(fetchCycles - 1);
    localparam logic [countWidth-1:0] lastDecode = countWidth'(decodeCycles - 1);

    ctrlPkg::ctrlStateT nextState;
    logic latchedTraps;
    logic decodeDone;
    logic overflowTrap;

    assign decodeDone = (state == ctrlPkg::stateDecode) && (phaseCount == lastDecode);
    assign overflowTrap = latchedTraps && overflow;

    always_comb begin
        nextState = state;
        case (state)
            ctrlPkg::stateReset: begin
                nextState = ctrlPkg::stateFetch;
            end
            ctrlPkg::stateFetch: begin
                if (phaseCount == lastFetch) begin
                    nextState = ctrlPkg::stateDecode;
                end
            end
            ctrlPkg::stateDecode: begin
                if (decodeDone) begin
                    case (instrKind)
                        ctrlPkg::instrJump: nextState = ctrlPkg::stateJump;
                        ctrlPkg::instrUnknown: nextState = ctrlPkg::stateException;
                        default: nextState = ctrlPkg::stateAluExec;
                    endcase
                end
            end
            ctrlPkg::stateAluExec: begin
                nextState = overflowTrap ? ctrlPkg::stateException : ctrlPkg::stateAluWrite;
            end
            default: begin
                // Write, jump and exception all take a single cycle
                nextState = ctrlPkg::stateFetch;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::stateReset;
            phaseCount <= '0;
        end else begin
            state <= nextState;
            // Counter restarts whenever the state changes
            phaseCount <= (nextState != state) ? '0 : phaseCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (decodeDone) begin
            latchedKind <= instrKind;
            latchedTraps <= trapsOnOverflow;
        end
        if (decodeDone && instrKind == ctrlPkg::instrUnknown) begin
            exceptionCause <= ctrlPkg::causeOpcode;
        end else if (state == ctrlPkg::stateAluExec && overflowTrap) begin
            exceptionCause <= ctrlPkg::causeOverflow;
        end
    end

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int period = 8,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // Released on a rising edge, seen by the DUT one edge later
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== dv/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb;

    localparam int fetchCycles = 4;
    localparam int decodeCycles = 2;
    localparam int waitLimit = 50;

    // Strobe masks in the bit order of strobes
    localparam logic [7:0] irBit = 8'h80;
    localparam logic [7:0] pcBit = 8'h40;
    localparam logic [7:0] abBit = 8'h30;
    localparam logic [7:0] aluOutBit = 8'h08;
    localparam logic [7:0] regBit = 8'h04;
    localparam logic [7:0] epcBit = 8'h02;
    localparam logic [7:0] resetOutBit = 8'h01;

    logic clk;
    logic reset;
    ctrlPkg::opcodeT opcode;
    ctrlPkg::functT funct;
    logic overflow;
    logic irWrite;
    logic pcWrite;
    logic writeA;
    logic writeB;
    logic aluOutWrite;
    logic regWrite;
    logic epcWrite;
    logic resetOut;
    logic [ctrlPkg::aluSrcAWidth-1:0] aluSrcA;
    logic [ctrlPkg::aluSrcBWidth-1:0] aluSrcB;
    logic [ctrlPkg::aluOpWidth-1:0] aluOperation;
    logic [ctrlPkg::pcSourceWidth-1:0] pcSource;
    logic [ctrlPkg::regDstWidth-1:0] regDst;
    logic [ctrlPkg::causeWidth-1:0] causeControl;
    logic [7:0] strobes;

    logic [7:0] expStrobes;
    logic [ctrlPkg::aluSrcAWidth-1:0] expSrcA;
    logic [ctrlPkg::aluSrcBWidth-1:0] expSrcB;
    logic [ctrlPkg::aluOpWidth-1:0] expAluOp;
    logic [ctrlPkg::pcSourceWidth-1:0] expPcSource;
    logic [ctrlPkg::regDstWidth-1:0] expRegDst;
    logic [ctrlPkg::causeWidth-1:0] expCause;
    logic [31:0] lcgState;
    int errorCount;

    assign strobes = {irWrite, pcWrite, writeA, writeB,
                      aluOutWrite, regWrite, epcWrite, resetOut};

    clockGen #(.period(8), .resetCycles(4)) clocks (.clk(clk), .reset(reset));

    controlUnit DUT (.*);

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic randomBit();
        logic [31:0] r;
        r = nextRandom();
        return r[31];
    endfunction

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s at %0t ns", what, $time);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on timeout");
    endtask

    task automatic clearExpected();
        expStrobes = '0;
        expSrcA = '0;
        expSrcB = '0;
        expAluOp = '0;
        expPcSource = '0;
        expRegDst = '0;
        expCause = '0;
    endtask

    task automatic compareOutputs(input string phase);
        checkValue({phase, " strobes"}, strobes, expStrobes);
        checkValue({phase, " aluSrcA"}, aluSrcA, expSrcA);
        checkValue({phase, " aluSrcB"}, aluSrcB, expSrcB);
        checkValue({phase, " aluOperation"}, aluOperation, expAluOp);
        checkValue({phase, " pcSource"}, pcSource, expPcSource);
        checkValue({phase, " regDst"}, regDst, expRegDst);
        checkValue({phase, " causeControl"}, causeControl, expCause);
    endtask

    // PC + 4 on every fetch cycle with the IR and PC load in the last
    task automatic fetchExpect(input logic lastCycle);
        clearExpected();
        expStrobes = lastCycle ? (irBit | pcBit) : 8'h00;
        expSrcA = ctrlPkg::aluSrcAPc;
        expSrcB = ctrlPkg::aluSrcBFour;
        expAluOp = ctrlPkg::aluOpAdd;
        expPcSource = ctrlPkg::pcSrcAluResult;
    endtask

    task automatic fetchRestart(input string label);
        for (int i = 0; i < fetchCycles - 1; i++) begin
            @(negedge clk);
            fetchExpect(1'b0);
            compareOutputs({label, " next fetch"});
        end
    endtask

    task automatic startInstruction(input ctrlPkg::opcodeT op, input ctrlPkg::functT fn,
                                    input logic ov, input string label);
        int waited;
        waited = 0;
        while (irWrite !== 1'b1) begin
            if (waited >= waitLimit) begin
                timeoutFail({"irWrite before ", label});
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        // Only the last fetch cycle is left after the checked ones
        checkValue({label, " cycles to irWrite"}, waited, 1);
        fetchExpect(1'b1);
        compareOutputs({label, " last fetch"});
        // New instruction word appears with the IR load
        @(posedge clk);
        opcode <= op;
        funct <= fn;
        overflow <= ov;
        for (int i = 0; i < decodeCycles; i++) begin
            @(negedge clk);
            clearExpected();
            expStrobes = abBit | aluOutBit;
            expSrcA = ctrlPkg::aluSrcAPc;
            expSrcB = ctrlPkg::aluSrcBBranch;
            expAluOp = ctrlPkg::aluOpAdd;
            compareOutputs({label, " decode"});
        end
    endtask

    task automatic execCycle(input logic [ctrlPkg::aluSrcBWidth-1:0] srcB,
                             input logic [ctrlPkg::aluOpWidth-1:0] aluOp, input string label);
        @(negedge clk);
        clearExpected();
        expStrobes = aluOutBit;
        expSrcA = ctrlPkg::aluSrcAReg;
        expSrcB = srcB;
        expAluOp = aluOp;
        compareOutputs({label, " execute"});
    endtask

    task automatic writeCycle(input logic [ctrlPkg::regDstWidth-1:0] dst, input string label);
        @(negedge clk);
        clearExpected();
        expStrobes = regBit;
        expRegDst = dst;
        compareOutputs({label, " write"});
    endtask

    task automatic exceptionCycle(input logic [ctrlPkg::causeWidth-1:0] cause,
                                  input string label);
        @(negedge clk);
        clearExpected();
        expStrobes = epcBit | pcBit;
        expPcSource = ctrlPkg::pcSrcExcVector;
        expCause = cause;
        compareOutputs({label, " exception"});
    endtask

    task automatic resetTest();
        int cycles;
        cycles = 0;
        @(posedge clk);
        @(negedge clk);
        while (reset === 1'b1) begin
            if (cycles >= waitLimit) begin
                timeoutFail("reset release");
            end else begin
                clearExpected();
                expStrobes = resetOutBit;
                compareOutputs("in reset");
                cycles++;
                @(negedge clk);
            end
        end
        // One extra cycle in the reset state
        clearExpected();
        expStrobes = resetOutBit;
        compareOutputs("reset release");
        fetchRestart("reset");
    endtask

    task automatic registerTest(input ctrlPkg::functT fn,
                                input logic [ctrlPkg::aluOpWidth-1:0] aluOp,
                                input logic ov, input string label);
        startInstruction(ctrlPkg::opRType, fn, ov, label);
        execCycle(ctrlPkg::aluSrcBReg, aluOp, label);
        writeCycle(ctrlPkg::regDstRd, label);
        fetchRestart(label);
    endtask

    task automatic immediateTest(input ctrlPkg::opcodeT op, input logic ov, input string label);
        startInstruction(op, ctrlPkg::functAdd, ov, label);
        execCycle(ctrlPkg::aluSrcBImm, ctrlPkg::aluOpAdd, label);
        writeCycle(ctrlPkg::regDstRt, label);
        fetchRestart(label);
    endtask

    task automatic overflowTest(input ctrlPkg::opcodeT op, input ctrlPkg::functT fn,
                                input logic [ctrlPkg::aluSrcBWidth-1:0] srcB,
                                input logic [ctrlPkg::aluOpWidth-1:0] aluOp,
                                input string label);
        startInstruction(op, fn, 1'b1, label);
        execCycle(srcB, aluOp, label);
        exceptionCycle(ctrlPkg::causeOverflow, label);
        fetchRestart(label);
    endtask

    task automatic unknownTest();
        logic [31:0] rnd;
        logic [5:0] op;
        logic [5:0] fn;
        string label;
        rnd = nextRandom();
        op = rnd[29:24];
        fn = rnd[21:16];
        if (rnd[31]) begin
            op = 6'h00;
        end else if (op == 6'h00 || op == 6'h02 || op == 6'h08 || op == 6'h09) begin
            op = op ^ 6'h20;
        end
        if (fn == 6'h20 || fn == 6'h22 || fn == 6'h24 || fn == 6'h2a) begin
            fn = fn ^ 6'h01;
        end
        label = $sformatf("unknown op %0h funct %0h", op, fn);
        startInstruction(ctrlPkg::opcodeT'(op), ctrlPkg::functT'(fn), rnd[30], label);
        exceptionCycle(ctrlPkg::causeOpcode, label);
        fetchRestart(label);
    endtask

    task automatic jumpTest(input logic ov);
        startInstruction(ctrlPkg::opJump, ctrlPkg::functAdd, ov, "J");
        @(negedge clk);
        clearExpected();
        expStrobes = pcBit;
        expPcSource = ctrlPkg::pcSrcJumpTarget;
        compareOutputs("J jump");
        fetchRestart("J");
    endtask

    initial begin
        errorCount = 0;
        lcgState = 32'h944aa870;
        opcode = ctrlPkg::opRType;
        funct = ctrlPkg::functAdd;
        overflow = 1'b0;
        clearExpected();
        resetTest();
        registerTest(ctrlPkg::functAdd, ctrlPkg::aluOpAdd, 1'b0, "ADD");
        registerTest(ctrlPkg::functSub, ctrlPkg::aluOpSub, 1'b0, "SUB");
        registerTest(ctrlPkg::functAnd, ctrlPkg::aluOpAnd, 1'b0, "AND");
        registerTest(ctrlPkg::functSlt, ctrlPkg::aluOpSlt, 1'b0, "SLT");
        // AND and SLT never trap on the flag
        registerTest(ctrlPkg::functAnd, ctrlPkg::aluOpAnd, randomBit(), "AND random flag");
        registerTest(ctrlPkg::functSlt, ctrlPkg::aluOpSlt, randomBit(), "SLT random flag");
        immediateTest(ctrlPkg::opAddi, 1'b0, "ADDI");
        immediateTest(ctrlPkg::opAddiu, 1'b1, "ADDIU");
        overflowTest(ctrlPkg::opRType, ctrlPkg::functAdd, ctrlPkg::aluSrcBReg,
                     ctrlPkg::aluOpAdd, "ADD overflow");
        overflowTest(ctrlPkg::opRType, ctrlPkg::functSub, ctrlPkg::aluSrcBReg,
                     ctrlPkg::aluOpSub, "SUB overflow");
        overflowTest(ctrlPkg::opAddi, ctrlPkg::functAdd, ctrlPkg::aluSrcBImm,
                     ctrlPkg::aluOpAdd, "ADDI overflow");
        repeat (6) unknownTest();
        jumpTest(randomBit());
        jumpTest(randomBit());
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
